// File: verilog/fetch_pkg.sv
/*
 * Shared constants of the fetch front end: address map, depths, widths
 * and fetch source IDs. Modules import it where they need it.
 */
`default_nettype none

package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // Local ROM region, bytes 0x00 to 0x7F
    localparam logic [31:0] LOCAL_BASE = 32'h0000_0000;
    localparam logic [31:0] LOCAL_WORDS = 32'd32;

    // External bus region
    localparam logic [31:0] BUS_BASE = 32'h8000_0000;
    localparam logic [31:0] BUS_SIZE = 32'h0001_0000;

    //////////////////////////////////////////////////////////////////////
    // Depths and widths
    //////////////////////////////////////////////////////////////////////
    localparam int MAX_INFLIGHT = 2;
    localparam int INFLIGHT_W = $clog2(MAX_INFLIGHT + 1);

    // Entries in the decode buffer, one credit each
    localparam int DECODE_CREDITS = 4;
    localparam int CREDIT_W = $clog2(DECODE_CREDITS + 1);

    // Fetch source IDs
    localparam logic SRC_LOCAL = 1'b0;
    localparam logic SRC_BUS = 1'b1;

    localparam string ROM_INIT_FILE = "rom_init.hex";

endpackage

`default_nettype wire

// File: verilog/fetch_issue.sv
/*
 * Fetch issue stage. Holds the PC and the decode credit counter, decodes
 * the PC against the address map and issues one request per cycle.
 */
`default_nettype none

module fetch_issue (
    input  logic        clk,
    input  logic        rst,

    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        credit_return,
    input  logic        discard,

    input  logic        attr_full,
    input  logic        bus_unit_ready,

    output logic        attr_push,
    output logic [31:0] attr_pc,
    output logic        attr_addr_valid,
    output logic        attr_src,

    output logic        rom_req,
    output logic        bus_fetch_req,
    output logic [31:0] fetch_addr
);
    import fetch_pkg::*;

    logic [31:0] pc;
    logic [CREDIT_W-1:0] credits;
    logic in_local;
    logic in_bus;
    logic issue;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////
    // Offset compare that wraps below the base to a large value
    assign in_local = (pc - LOCAL_BASE) < (LOCAL_WORDS << 2);
    assign in_bus = (pc - BUS_BASE) < BUS_SIZE;

    // Unmapped addresses still issue so they can complete with a fault
    assign issue = ~rst & (credits != '0) & ~attr_full & bus_unit_ready & ~redirect;

    //////////////////////////////////////////////////////////////////////
    // PC
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= {redirect_pc[31:2], 2'b00};
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode credits
    //////////////////////////////////////////////////////////////////////
    // Discarded fetches never reach decode, so their credit comes back here
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(DECODE_CREDITS);
        end else begin
            credits <= credits - CREDIT_W'(issue) + CREDIT_W'(credit_return)
                       + CREDIT_W'(discard);
        end
    end

    // Attributes for every issued request
    assign attr_push = issue;
    assign attr_pc = pc;
    assign attr_addr_valid = in_local | in_bus;
    assign attr_src = in_bus ? SRC_BUS : SRC_LOCAL;

    // Requests to the sources
    assign rom_req = issue & in_local;
    assign bus_fetch_req = issue & in_bus;
    assign fetch_addr = pc;

endmodule

`default_nettype wire

// File: verilog/fetch_attr_fifo.sv
/*
 * In-order FIFO of per-request fetch attributes, one entry per fetch in
 * flight. Its occupancy feeds the flush count in the response stage.
 */
`default_nettype none

module fetch_attr_fifo (
    input  logic        clk,
    input  logic        rst,

    input  logic        attr_push,
    input  logic [31:0] attr_pc,
    input  logic        attr_addr_valid,
    input  logic        attr_src,
    input  logic        attr_pop,

    output logic        attr_full,
    output logic        head_valid,
    output logic [31:0] head_pc,
    output logic        head_addr_valid,
    output logic        head_src,
    output logic [fetch_pkg::INFLIGHT_W-1:0] inflight_count
);
    import fetch_pkg::*;

    logic [31:0] pc_mem [MAX_INFLIGHT];
    logic addr_valid_mem [MAX_INFLIGHT];
    logic src_mem [MAX_INFLIGHT];

    // Depth is a power of two, pointers wrap on their own
    logic [$clog2(MAX_INFLIGHT)-1:0] wr_ptr;
    logic [$clog2(MAX_INFLIGHT)-1:0] rd_ptr;
    logic [INFLIGHT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + $bits(wr_ptr)'(attr_push);
            rd_ptr <= rd_ptr + $bits(rd_ptr)'(attr_pop);
            count <= count + INFLIGHT_W'(attr_push) - INFLIGHT_W'(attr_pop);
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (attr_push) begin
            pc_mem[wr_ptr] <= attr_pc;
            addr_valid_mem[wr_ptr] <= attr_addr_valid;
            src_mem[wr_ptr] <= attr_src;
        end
    end

    assign attr_full = count == INFLIGHT_W'(MAX_INFLIGHT);
    assign head_valid = count != '0;
    assign head_pc = pc_mem[rd_ptr];
    assign head_addr_valid = addr_valid_mem[rd_ptr];
    assign head_src = src_mem[rd_ptr];
    assign inflight_count = count;

endmodule

`default_nettype wire

// File: verilog/local_rom_unit.sv
/*
 * Local instruction ROM, preloaded from a hex file. Read data and its
 * valid flag appear one cycle after the request.
 */
`default_nettype none

module local_rom_unit (
    input  logic        clk,
    input  logic        rom_req,
    input  logic [31:0] fetch_addr,
    output logic        rom_data_valid,
    output logic [31:0] rom_data
);
    import fetch_pkg::*;

    logic [31:0] rom [LOCAL_WORDS];
    logic [31:0] rom_offset;

    initial begin
        $readmemh(ROM_INIT_FILE, rom);
    end

    // Word index within the region
    assign rom_offset = fetch_addr - LOCAL_BASE;

    always_ff @(posedge clk) begin
        rom_data_valid <= rom_req;
        if (rom_req) begin
            rom_data <= rom[rom_offset[$clog2(LOCAL_WORDS)+1:2]];
        end
    end

endmodule

`default_nettype wire

// File: verilog/bus_fetch_unit.sv
/*
 * Fetch master for the external bus region. Handles one request at a
 * time and reports ready only while idle.
 */
`default_nettype none

module bus_fetch_unit (
    input  logic        clk,
    input  logic        rst,

    input  logic        bus_fetch_req,
    input  logic [31:0] fetch_addr,
    output logic        bus_unit_ready,
    output logic        bus_data_valid,
    output logic [31:0] bus_data,

    output logic        bus_req,
    output logic [31:0] bus_addr,
    input  logic        bus_ack,
    input  logic [31:0] bus_rdata
);

    // Idle, request and return held as two flags, idle when both are low
    logic req_active;
    logic rsp_active;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_active <= 1'b0;
            rsp_active <= 1'b0;
        end else begin
            rsp_active <= req_active & bus_ack;
            if (bus_fetch_req) begin
                req_active <= 1'b1;
            end else if (bus_ack) begin
                req_active <= 1'b0;
            end
        end
    end

    // Address and read data
    always_ff @(posedge clk) begin
        if (bus_fetch_req) begin
            bus_addr <= fetch_addr;
        end
        if (req_active & bus_ack) begin
            bus_data <= bus_rdata;
        end
    end

    assign bus_req = req_active;
    assign bus_data_valid = rsp_active;
    assign bus_unit_ready = ~req_active & ~rsp_active;

endmodule

`default_nettype wire

// File: verilog/fetch_response.sv
/*
 * Fetch response stage. Pops the head attribute entry once its source
 * returns data, drops responses flushed by a redirect, drives completion.
 */
`default_nettype none

module fetch_response (
    input  logic        clk,
    input  logic        rst,

    input  logic        redirect,
    input  logic [fetch_pkg::INFLIGHT_W-1:0] inflight_count,

    input  logic        head_valid,
    input  logic [31:0] head_pc,
    input  logic        head_addr_valid,
    input  logic        head_src,

    input  logic        rom_data_valid,
    input  logic [31:0] rom_data,
    input  logic        bus_data_valid,
    input  logic [31:0] bus_data,

    output logic        attr_pop,
    output logic        discard,
    output logic        fetch_complete,
    output logic [31:0] fetch_pc,
    output logic [31:0] fetch_instruction,
    output logic        fetch_ok
);
    import fetch_pkg::*;

    logic [INFLIGHT_W-1:0] flush_count;
    logic flushing;
    logic head_data_valid;
    logic [31:0] head_data;

    //////////////////////////////////////////////////////////////////////
    // Head result selection
    //////////////////////////////////////////////////////////////////////
    assign head_data_valid = (head_src == SRC_BUS) ? bus_data_valid : rom_data_valid;
    assign head_data = (head_src == SRC_BUS) ? bus_data : rom_data;

    // Unmapped entries leave as soon as they reach the head
    assign attr_pop = head_valid & (~head_addr_valid | head_data_valid);

    //////////////////////////////////////////////////////////////////////
    // Flush tracking
    //////////////////////////////////////////////////////////////////////
    // Entries left in flight after a redirect all belong to the old path
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_count <= '0;
        end else if (redirect) begin
            flush_count <= inflight_count - INFLIGHT_W'(attr_pop);
        end else if (flushing & attr_pop) begin
            flush_count <= flush_count - 1'b1;
        end
    end

    assign flushing = flush_count != '0;

    // A pop in the redirect cycle is also from the old path
    assign discard = attr_pop & (flushing | redirect);
    assign fetch_complete = attr_pop & ~flushing & ~redirect;

    assign fetch_pc = head_pc;
    assign fetch_instruction = head_addr_valid ? head_data : 32'h0000_0000;
    assign fetch_ok = head_addr_valid;

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
/*
 * Top level of the fetch front end: issue, attribute FIFO, ROM and bus
 * sources in parallel, then in-order response.
 */
`default_nettype none

module fetch_top (
    input  logic        clk,
    input  logic        rst,

    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        credit_return,

    output logic        bus_req,
    output logic [31:0] bus_addr,
    input  logic        bus_ack,
    input  logic [31:0] bus_rdata,

    output logic        fetch_complete,
    output logic [31:0] fetch_pc,
    output logic [31:0] fetch_instruction,
    output logic        fetch_ok
);
    import fetch_pkg::*;

    // Issue to FIFO and sources
    logic attr_push;
    logic [31:0] attr_pc;
    logic attr_addr_valid;
    logic attr_src;
    logic attr_full;
    logic rom_req;
    logic bus_fetch_req;
    logic [31:0] fetch_addr;
    logic bus_unit_ready;

    // FIFO head
    logic head_valid;
    logic [31:0] head_pc;
    logic head_addr_valid;
    logic head_src;
    logic [INFLIGHT_W-1:0] inflight_count;
    logic attr_pop;
    logic discard;

    // Source results
    logic rom_data_valid;
    logic [31:0] rom_data;
    logic bus_data_valid;
    logic [31:0] bus_data;

    fetch_issue u_issue (
        .clk             (clk),
        .rst             (rst),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .credit_return   (credit_return),
        .discard         (discard),
        .attr_full       (attr_full),
        .bus_unit_ready  (bus_unit_ready),
        .attr_push       (attr_push),
        .attr_pc         (attr_pc),
        .attr_addr_valid (attr_addr_valid),
        .attr_src        (attr_src),
        .rom_req         (rom_req),
        .bus_fetch_req   (bus_fetch_req),
        .fetch_addr      (fetch_addr)
    );

    fetch_attr_fifo u_attr_fifo (
        .clk             (clk),
        .rst             (rst),
        .attr_push       (attr_push),
        .attr_pc         (attr_pc),
        .attr_addr_valid (attr_addr_valid),
        .attr_src        (attr_src),
        .attr_pop        (attr_pop),
        .attr_full       (attr_full),
        .head_valid      (head_valid),
        .head_pc         (head_pc),
        .head_addr_valid (head_addr_valid),
        .head_src        (head_src),
        .inflight_count  (inflight_count)
    );

    local_rom_unit u_rom (
        .clk            (clk),
        .rom_req        (rom_req),
        .fetch_addr     (fetch_addr),
        .rom_data_valid (rom_data_valid),
        .rom_data       (rom_data)
    );

    bus_fetch_unit u_bus (
        .clk            (clk),
        .rst            (rst),
        .bus_fetch_req  (bus_fetch_req),
        .fetch_addr     (fetch_addr),
        .bus_unit_ready (bus_unit_ready),
        .bus_data_valid (bus_data_valid),
        .bus_data       (bus_data),
        .bus_req        (bus_req),
        .bus_addr       (bus_addr),
        .bus_ack        (bus_ack),
        .bus_rdata      (bus_rdata)
    );

    fetch_response u_response (
        .clk               (clk),
        .rst               (rst),
        .redirect          (redirect),
        .inflight_count    (inflight_count),
        .head_valid        (head_valid),
        .head_pc           (head_pc),
        .head_addr_valid   (head_addr_valid),
        .head_src          (head_src),
        .rom_data_valid    (rom_data_valid),
        .rom_data          (rom_data),
        .bus_data_valid    (bus_data_valid),
        .bus_data          (bus_data),
        .attr_pop          (attr_pop),
        .discard           (discard),
        .fetch_complete    (fetch_complete),
        .fetch_pc          (fetch_pc),
        .fetch_instruction (fetch_instruction),
        .fetch_ok          (fetch_ok)
    );

endmodule

`default_nettype wire

// File: testbench/fetch_checker.sv
/*
 * Fetch checker. Follows the expected PC stream, compares each completed
 * fetch with a reference model, checks the bus handshake and tracks decode.
 */
`default_nettype none

module fetch_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  test_id,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        credit_return,
    input  logic        bus_req,
    input  logic [31:0] bus_addr,
    input  logic        bus_ack,
    input  logic        fetch_complete,
    input  logic [31:0] fetch_pc,
    input  logic [31:0] fetch_instruction,
    input  logic        fetch_ok,
    output int          error_count,
    output int          complete_count,
    output int          pending_count
);
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    logic [31:0] rom_model [LOCAL_WORDS];
    logic [31:0] expected_pc;
    logic        bus_waiting;
    logic        bus_acked;
    logic [31:0] bus_held_addr;

    initial begin
        $readmemh("rom_init.hex", rom_model);
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "seq_rom";
            3'd2: return "bus_fetch";
            3'd3: return "unmapped";
            3'd4: return "redirect";
            3'd5: return "credits";
            default: return "reset";
        endcase
    endfunction

    // Bus memory contents built from every address bit
    function automatic logic [31:0] bus_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    // Expected {ok, instruction} for a fetch address
    function automatic logic [32:0] expected_fetch(input logic [31:0] addr);
        logic [31:0] rom_offset;
        logic [31:0] bus_offset;
        rom_offset = addr - LOCAL_BASE;
        bus_offset = addr - BUS_BASE;
        if (rom_offset < LOCAL_WORDS * 4) begin
            return {1'b1, rom_model[rom_offset[31:2]]};
        end
        if (bus_offset < BUS_SIZE) begin
            return {1'b1, bus_word(addr)};
        end
        return {1'b0, 32'h0000_0000};
    endfunction

    task automatic compare(input string field, input logic [31:0] exp_value,
                           input logic [31:0] act_value);
        if (act_value !== exp_value) begin
            $display("Mismatch in %s, %s at pc 0x%08h: expected 0x%08h, actual 0x%08h",
                     test_name(test_id), field, expected_pc, exp_value, act_value);
            error_count = error_count + 1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Comparison
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        logic [32:0] expected;
        if (rst) begin
            expected_pc = RESET_PC;
            error_count = 0;
            complete_count = 0;
            pending_count = 0;
            bus_waiting = 1'b0;
            bus_acked = 1'b0;
            bus_held_addr = '0;
        end else begin
            if (fetch_complete) begin
                expected = expected_fetch(expected_pc);
                complete_count = complete_count + 1;
                compare("pc", expected_pc, fetch_pc);
                compare("ok", 32'(expected[32]), 32'(fetch_ok));
                // A faulting fetch defines only its ok flag
                if (expected[32]) begin
                    compare("instruction", expected[31:0], fetch_instruction);
                end
            end
            if (redirect) begin
                expected_pc = redirect_pc;
            end else if (fetch_complete) begin
                expected_pc = expected_pc + 32'd4;
            end
            pending_count = pending_count + int'(fetch_complete) - int'(credit_return);
            if (pending_count > DECODE_CREDITS) begin
                $display("Decode buffer overflow in %s, %0d entries held with %0d credits",
                         test_name(test_id), pending_count, DECODE_CREDITS);
                error_count = error_count + 1;
            end

            // Bus request and address hold until bus_ack, then the request drops
            if (bus_waiting && !bus_req) begin
                $display("Bus request in %s dropped before bus_ack arrived",
                         test_name(test_id));
                error_count = error_count + 1;
            end else if (bus_waiting && bus_addr !== bus_held_addr) begin
                $display("Mismatch in %s, bus_addr before bus_ack: %s0x%08h, actual 0x%08h",
                         test_name(test_id), "expected ", bus_held_addr, bus_addr);
                error_count = error_count + 1;
            end
            if (bus_acked && bus_req) begin
                $display("Bus request in %s stayed high after bus_ack", test_name(test_id));
                error_count = error_count + 1;
            end
            bus_waiting = bus_req && !bus_ack;
            bus_acked = bus_req && bus_ack;
            bus_held_addr = bus_addr;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_fetch.sv
/*
 * Top-level testbench of the fetch front end. Drives redirects and credit
 * returns on the falling edge, models the external bus and runs the tests.
 */
`default_nettype none

module tb_fetch;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS = 5;
    localparam int CYCLES_PER_TEST = 400;
    localparam int WAIT_LIMIT = 300;
    localparam int QUIET_CYCLES = 20;

    logic        clk = 1'b0;
    logic        rst;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        credit_return;
    logic        bus_req;
    logic [31:0] bus_addr;
    logic        bus_ack;
    logic [31:0] bus_rdata;
    logic        fetch_complete;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_instruction;
    logic        fetch_ok;

    logic [2:0]  test_id;
    int          error_count;
    int          complete_count;
    int          pending_count;
    int          tb_errors = 0;
    int          tests_failed = 0;
    int          errors_base;
    int          count_base;
    bit          return_en;
    int          burst_left;
    integer      seed = 32'hcd4d;

    always #(CLK_PERIOD / 2) clk = ~clk;

    fetch_top dut (
        .clk               (clk),
        .rst               (rst),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .credit_return     (credit_return),
        .bus_req           (bus_req),
        .bus_addr          (bus_addr),
        .bus_ack           (bus_ack),
        .bus_rdata         (bus_rdata),
        .fetch_complete    (fetch_complete),
        .fetch_pc          (fetch_pc),
        .fetch_instruction (fetch_instruction),
        .fetch_ok          (fetch_ok)
    );

    fetch_checker chk (
        .clk               (clk),
        .rst               (rst),
        .test_id           (test_id),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .credit_return     (credit_return),
        .bus_req           (bus_req),
        .bus_addr          (bus_addr),
        .bus_ack           (bus_ack),
        .fetch_complete    (fetch_complete),
        .fetch_pc          (fetch_pc),
        .fetch_instruction (fetch_instruction),
        .fetch_ok          (fetch_ok),
        .error_count       (error_count),
        .complete_count    (complete_count),
        .pending_count     (pending_count)
    );

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////
    // Decode consumes one buffered entry per cycle when allowed
    task automatic step();
        @(negedge clk);
        redirect = 1'b0;
        if (burst_left > 0) begin
            credit_return = 1'b1;
            burst_left = burst_left - 1;
        end else begin
            credit_return = return_en && (pending_count > 0);
        end
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        step();
        redirect = 1'b1;
        redirect_pc = pc;
    endtask

    task automatic wait_completions(input int n);
        int target;
        int cycles;
        target = complete_count + n;
        cycles = 0;
        while (complete_count < target && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (complete_count < target) begin
            $display("Timed out in %s waiting for %0d completions, %0d arrived",
                     chk.test_name(test_id), n, n - (target - complete_count));
            tb_errors++;
        end
    endtask

    // Runs until no fetch has completed for a while
    task automatic wait_quiet();
        int last;
        int idle;
        int cycles;
        last = complete_count;
        idle = 0;
        cycles = 0;
        while (idle < QUIET_CYCLES && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
            if (complete_count == last) begin
                idle++;
            end else begin
                idle = 0;
                last = complete_count;
            end
        end
        if (idle < QUIET_CYCLES) begin
            $display("Completions did not stop in %s", chk.test_name(test_id));
            tb_errors++;
        end
    endtask

    task automatic start_test(input logic [2:0] id);
        test_id = id;
        errors_base = error_count + tb_errors;
        count_base = complete_count;
    endtask

    task automatic finish_test();
        int errs;
        errs = error_count + tb_errors - errors_base;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("%s: %s, %0d completions, %0d errors", chk.test_name(test_id),
                 (errs == 0) ? "pass" : "FAIL", complete_count - count_base, errs);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus memory model
    //////////////////////////////////////////////////////////////////////
    initial begin
        int delay;
        bit serving;
        bus_ack = 1'b0;
        bus_rdata = '0;
        serving = 1'b0;
        delay = 0;
        forever begin
            @(negedge clk);
            bus_ack = 1'b0;
            if (rst) begin
                serving = 1'b0;
            end else begin
                if (!serving && bus_req) begin
                    serving = 1'b1;
                    delay = $unsigned($random(seed)) % 6;
                end
                if (serving) begin
                    if (delay == 0) begin
                        bus_ack = 1'b1;
                        bus_rdata = chk.bus_word(bus_addr);
                        serving = 1'b0;
                    end else begin
                        delay = delay - 1;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int base;
        int total_errors;
        rst = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        credit_return = 1'b0;
        test_id = 3'd0;
        return_en = 1'b0;
        burst_left = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        return_en = 1'b1;

        start_test(3'd1);
        wait_completions(16);
        finish_test();

        start_test(3'd2);
        redirect_to(BUS_BASE + 32'h100);
        wait_completions(12);
        finish_test();

        // Gap between the ROM and the bus region
        start_test(3'd3);
        redirect_to(32'h0000_1000);
        wait_completions(8);
        finish_test();

        // Second redirect lands while bus fetches are in flight
        start_test(3'd4);
        redirect_to(BUS_BASE + 32'h200);
        wait_completions(3);
        redirect_to(LOCAL_BASE + 32'h10);
        wait_completions(6);
        finish_test();

        start_test(3'd5);
        return_en = 1'b0;
        wait_quiet();
        if (pending_count != DECODE_CREDITS) begin
            $display("Decode buffer holds %0d entries while stalled, expected %0d",
                     pending_count, DECODE_CREDITS);
            tb_errors++;
        end
        base = complete_count;
        burst_left = DECODE_CREDITS;
        wait_quiet();
        if (complete_count - base != DECODE_CREDITS) begin
            $display("%0d fetches completed after the credit burst, expected %0d",
                     complete_count - base, DECODE_CREDITS);
            tb_errors++;
        end
        return_en = 1'b1;
        wait_completions(4);
        finish_test();

        total_errors = error_count + tb_errors;
        $display("Tests run %0d, failed %0d, completions %0d, errors %0d",
                 NUM_TESTS, tests_failed, complete_count, total_errors);
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired after %0d ns, the tests did not finish",
                 NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rom_init.hex
// Local ROM image, one 32-bit instruction word per line
// Line n holds the word at byte address 4*n
00000013
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813
01100893
01200913
01300993
01400a13
01500a93
01600b13
01700b93
01800c13
01900c93
01a00d13
01b00d93
01c00e13
01d00e93
01e00f13
01f00f93

// File: sources.f
verilog/fetch_pkg.sv
verilog/fetch_issue.sv
verilog/fetch_attr_fifo.sv
verilog/local_rom_unit.sv
verilog/bus_fetch_unit.sv
verilog/fetch_response.sv
verilog/fetch_top.sv
testbench/fetch_checker.sv
testbench/tb_fetch.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench
TOP = tb_fetch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f sources.f -o V$(TOP)

# Passes only when the pass line shows up in the simulation output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
